// ==== rtl/blk_ll_mgr.sv ====
// ------------------------------
// Block list manager
// Free list and per-queue linked lists over one shared next-pointer
// store, with FL flags and an edge-triggered status read register
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module blk_ll_mgr (
  input  logic                                              prim_nonflr_clk,
  input  logic                                              prim_gated_rst_b,
  input  blk_pool_pkg::ll_ctl_t                             cfg,          // Status read control
  output blk_pool_pkg::fl_status_t                          fl_stat,
  output blk_pool_pkg::ll_status_t                          ll_stat,
  input  logic                                              alloc_v,      // Pop FL, push LL
  input  logic [blk_pool_pkg::LL_W-1:0]                     alloc_ll,
  input  logic                                              ll_pop,       // Pop LL head
  input  logic [blk_pool_pkg::LL_W-1:0]                     ll_pop_ll,
  input  logic                                              fl_push,      // Return to FL tail
  input  logic [blk_pool_pkg::PTR_W-1:0]                    fl_push_ptr,
  output logic [blk_pool_pkg::NUM_LLS-1:0]                  ll_v,
  output logic [blk_pool_pkg::NUM_LLS-1:0][blk_pool_pkg::PTR_W-1:0] ll_hptr
);

  import blk_pool_pkg::*;

  // ------------------------------
  // State

  logic [PTR_W-1:0]              blk_nxt_q [FL_DEPTH];  // One link per block
  logic [PTR_W-1:0]              blk_nxt_d [FL_DEPTH];

  logic [PTR_W-1:0]              fl_hptr_q;
  logic [PTR_W-1:0]              fl_hptr_d;
  logic [PTR_W-1:0]              fl_tptr_q;
  logic [PTR_W-1:0]              fl_tptr_d;
  logic [CNT_W-1:0]              fl_cnt_q;
  logic [CNT_W-1:0]              fl_cnt_d;
  logic                          fl_empty_q;
  logic                          fl_aempty_q;
  logic                          fl_full_q;

  logic [NUM_LLS-1:0][PTR_W-1:0] ll_hptr_q;
  logic [NUM_LLS-1:0][PTR_W-1:0] ll_hptr_d;
  logic [NUM_LLS-1:0][PTR_W-1:0] ll_tptr_q;
  logic [NUM_LLS-1:0][PTR_W-1:0] ll_tptr_d;
  logic [NUM_LLS-1:0]            ll_v_q;
  logic [NUM_LLS-1:0]            ll_v_d;
  logic                          pop_last;   // Popping the only block of a list

  logic [1:0]                    rd_q;       // Previous {rd_blk, rd_ll}
  ll_status_t                    stat_q;
  ll_status_t                    stat_d;

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      // Whole pool chained on the FL, 0 -> 1 -> ... -> 15
      for (int i = 0; i < FL_DEPTH; i++) begin
        blk_nxt_q[i] <= PTR_W'(i + 1);
      end
      fl_hptr_q   <= '0;
      fl_tptr_q   <= PTR_W'(FL_DEPTH - 1);
      fl_cnt_q    <= CNT_W'(FL_DEPTH);
      fl_empty_q  <= 1'b0;
      fl_aempty_q <= 1'b0;
      fl_full_q   <= 1'b1;
      ll_hptr_q   <= '0;
      ll_tptr_q   <= '0;
      ll_v_q      <= '0;
    end else begin
      blk_nxt_q   <= blk_nxt_d;
      fl_hptr_q   <= fl_hptr_d;
      fl_tptr_q   <= fl_tptr_d;
      fl_cnt_q    <= fl_cnt_d;
      fl_empty_q  <= (fl_cnt_d == '0);                       // Flags from next count
      fl_aempty_q <= (fl_cnt_d <= {1'b0, cfg.aempty_lim});
      fl_full_q   <= (fl_cnt_d == CNT_W'(FL_DEPTH));
      ll_hptr_q   <= ll_hptr_d;
      ll_tptr_q   <= ll_tptr_d;
      ll_v_q      <= ll_v_d;
    end
  end

  // ------------------------------
  // Next state, alloc then pop then push

  always_comb begin
    blk_nxt_d = blk_nxt_q;
    fl_hptr_d = fl_hptr_q;
    fl_tptr_d = fl_tptr_q;
    ll_hptr_d = ll_hptr_q;
    ll_tptr_d = ll_tptr_q;
    ll_v_d    = ll_v_q;
    pop_last  = ll_pop && (ll_hptr_q[ll_pop_ll] == ll_tptr_q[ll_pop_ll]);

    if (alloc_v) begin
      fl_hptr_d = blk_nxt_q[fl_hptr_q];  // FL head advances
      if (ll_v_q[alloc_ll] && !(pop_last && (ll_pop_ll == alloc_ll))) begin
        // Link behind the current tail
        blk_nxt_d[ll_tptr_q[alloc_ll]] = fl_hptr_q;
        ll_tptr_d[alloc_ll]            = fl_hptr_q;
      end else begin
        // Empty list, or its last block leaves now
        ll_v_d[alloc_ll]    = 1'b1;
        ll_hptr_d[alloc_ll] = fl_hptr_q;
        ll_tptr_d[alloc_ll] = fl_hptr_q;
      end
    end

    if (ll_pop) begin
      if (!pop_last) begin
        ll_hptr_d[ll_pop_ll] = blk_nxt_q[ll_hptr_q[ll_pop_ll]];
      end else if (!(alloc_v && (alloc_ll == ll_pop_ll))) begin
        ll_v_d[ll_pop_ll] = 1'b0;  // List drained
      end
    end

    if (fl_push) begin
      fl_tptr_d = fl_push_ptr;
      if (fl_empty_q || (alloc_v && (fl_cnt_q == CNT_W'(1)))) begin
        fl_hptr_d = fl_push_ptr;              // FL restarts at the returned block
      end else begin
        blk_nxt_d[fl_tptr_q] = fl_push_ptr;  // Append after FL tail
      end
    end

    // Pop and push together leave the count alone
    case ({alloc_v, fl_push})
      2'b10:   fl_cnt_d = fl_cnt_q - CNT_W'(1);
      2'b01:   fl_cnt_d = fl_cnt_q + CNT_W'(1);
      default: fl_cnt_d = fl_cnt_q;
    endcase
  end

  // ------------------------------
  // Status read, loads on rising read bits

  always_comb begin
    stat_d = stat_q;
    if (cfg.rd_blk && !rd_q[1]) begin        // Block read wins
      stat_d      = '0;
      stat_d.tptr = blk_nxt_q[cfg.ptr];
    end else if (cfg.rd_ll && !rd_q[0]) begin
      stat_d.kind = 1'b1;
      stat_d.v    = ll_v_q[cfg.ptr[LL_W-1:0]];
      stat_d.hptr = ll_hptr_q[cfg.ptr[LL_W-1:0]];
      stat_d.tptr = ll_tptr_q[cfg.ptr[LL_W-1:0]];
    end
  end

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      rd_q   <= '0;
      stat_q <= '0;
    end else begin
      rd_q   <= {cfg.rd_blk, cfg.rd_ll};
      stat_q <= stat_d;
    end
  end

  assign fl_stat = '{full:   fl_full_q,
                     aempty: fl_aempty_q,
                     empty:  fl_empty_q,
                     cnt:    fl_cnt_q,
                     hptr:   fl_hptr_q};
  assign ll_stat = stat_q;
  assign ll_v    = ll_v_q;
  assign ll_hptr = ll_hptr_q;

endmodule

`default_nettype wire

// ==== rtl/blk_pool_pkg.sv ====
// ------------------------------
// Block pool package
// Sizes, control and status words and the issue record shared by the
// block-pool manager, the issue arbiter and the return queue
// ------------------------------
`default_nettype none

package blk_pool_pkg;

  // Sizes ------------------------------
  localparam int NUM_LLS  = 4;   // Per-queue linked lists
  localparam int LL_W     = 2;   // List index width
  localparam int FL_DEPTH = 16;  // Blocks in the pool
  localparam int PTR_W    = 4;   // Block pointer width
  localparam int CNT_W    = 5;   // FL count, 0..16

  // Configuration word, 10 bits
  typedef struct packed {
    logic             rd_ll;       // Read list, rising edge
    logic             rd_blk;      // Read block, rising edge
    logic [PTR_W-1:0] ptr;         // List or block index
    logic [PTR_W-1:0] aempty_lim;  // FL almost-empty threshold
  } ll_ctl_t;

  // Free list status, 12 bits
  typedef struct packed {
    logic             full;
    logic             aempty;
    logic             empty;
    logic [CNT_W-1:0] cnt;
    logic [PTR_W-1:0] hptr;
  } fl_status_t;

  // List or block read result, 10 bits
  typedef struct packed {
    logic             kind;  // 1 list read, 0 block read
    logic             v;
    logic [PTR_W-1:0] hptr;
    logic [PTR_W-1:0] tptr;  // Next-pointer on a block read
  } ll_status_t;

  // Issue record
  typedef struct packed {
    logic [LL_W-1:0]  ll;
    logic [PTR_W-1:0] ptr;
  } issue_t;

endpackage

`default_nettype wire

// ==== rtl/blk_pool_top.sv ====
// ------------------------------
// Block pool top
// List manager, issue arbiter and completion return queue
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module blk_pool_top (
  input  logic                               prim_nonflr_clk,
  input  logic                               prim_gated_rst_b,
  input  logic                               alloc_v,
  input  logic [blk_pool_pkg::LL_W-1:0]      alloc_ll,
  input  logic                               issue_rdy,
  input  logic                               cpl_v,
  input  blk_pool_pkg::ll_ctl_t              cfg,
  output blk_pool_pkg::fl_status_t           fl_stat,
  output blk_pool_pkg::ll_status_t           ll_stat,
  output logic [blk_pool_pkg::NUM_LLS-1:0]   ll_v,
  output logic                               issue_v,
  output blk_pool_pkg::issue_t               issue
);

  import blk_pool_pkg::*;

  logic [NUM_LLS-1:0][PTR_W-1:0] ll_hptr;     // Heads for the arbiter
  logic                          ll_pop;
  logic [LL_W-1:0]               ll_pop_ll;
  logic                          fl_push;     // Returned block
  logic [PTR_W-1:0]              fl_push_ptr;

  blk_ll_mgr u_mgr (
    .prim_nonflr_clk  (prim_nonflr_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .cfg              (cfg),
    .fl_stat          (fl_stat),
    .ll_stat          (ll_stat),
    .alloc_v          (alloc_v),
    .alloc_ll         (alloc_ll),
    .ll_pop           (ll_pop),
    .ll_pop_ll        (ll_pop_ll),
    .fl_push          (fl_push),
    .fl_push_ptr      (fl_push_ptr),
    .ll_v             (ll_v),
    .ll_hptr          (ll_hptr)
  );

  ll_issue_arb u_arb (
    .prim_nonflr_clk  (prim_nonflr_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .issue_rdy        (issue_rdy),
    .ll_v             (ll_v),
    .ll_hptr          (ll_hptr),
    .ll_pop           (ll_pop),
    .ll_pop_ll        (ll_pop_ll),
    .issue_v          (issue_v),
    .issue            (issue)
  );

  // Popped head goes straight into the return queue
  cpl_return_q u_retq (
    .prim_nonflr_clk  (prim_nonflr_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .push             (ll_pop),
    .push_ptr         (ll_hptr[ll_pop_ll]),
    .cpl_v            (cpl_v),
    .fl_push          (fl_push),
    .fl_push_ptr      (fl_push_ptr)
  );

endmodule

`default_nettype wire

// ==== rtl/cpl_return_q.sv ====
// ------------------------------
// Completion return queue
// Holds issued blocks in order and hands the oldest back to the FL
// on each completion strobe
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpl_return_q (
  input  logic                            prim_nonflr_clk,
  input  logic                            prim_gated_rst_b,
  input  logic                            push,          // Block issued
  input  logic [blk_pool_pkg::PTR_W-1:0]  push_ptr,
  input  logic                            cpl_v,         // Completion strobe
  output logic                            fl_push,
  output logic [blk_pool_pkg::PTR_W-1:0]  fl_push_ptr
);

  import blk_pool_pkg::*;

  // 16 entries is enough, only 16 blocks exist
  logic [PTR_W-1:0] ent_q [FL_DEPTH];
  logic [CNT_W-1:0] wr_q;     // Extra bit tells full from empty
  logic [CNT_W-1:0] rd_q;
  logic             q_empty;

  assign q_empty = (wr_q == rd_q);

  // Same-cycle completion of a block issued this cycle bypasses storage
  assign fl_push     = cpl_v;
  assign fl_push_ptr = q_empty ? push_ptr : ent_q[rd_q[PTR_W-1:0]];

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      wr_q <= '0;
      rd_q <= '0;
    end else begin
      if (push) begin
        wr_q <= wr_q + CNT_W'(1);
      end
      if (cpl_v) begin
        rd_q <= rd_q + CNT_W'(1);
      end
    end
  end

  // Entry storage
  always_ff @(posedge prim_nonflr_clk) begin
    if (push) begin
      ent_q[wr_q[PTR_W-1:0]] <= push_ptr;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ll_issue_arb.sv ====
// ------------------------------
// List issue arbiter
// Round-robin pick among valid lists, pops the winner's head and
// registers the issue record
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module ll_issue_arb (
  input  logic                                              prim_nonflr_clk,
  input  logic                                              prim_gated_rst_b,
  input  logic                                              issue_rdy,   // Consumer ready level
  input  logic [blk_pool_pkg::NUM_LLS-1:0]                  ll_v,
  input  logic [blk_pool_pkg::NUM_LLS-1:0][blk_pool_pkg::PTR_W-1:0] ll_hptr,
  output logic                                              ll_pop,
  output logic [blk_pool_pkg::LL_W-1:0]                     ll_pop_ll,
  output logic                                              issue_v,
  output blk_pool_pkg::issue_t                              issue
);

  import blk_pool_pkg::*;

  logic [LL_W-1:0] rr_q;   // First list to look at
  logic [LL_W-1:0] cand;
  logic [LL_W-1:0] win;
  logic            found;

  // Search from rr_q upward with wrap
  always_comb begin
    found = 1'b0;
    win   = rr_q;
    cand  = rr_q;
    for (int i = 0; i < NUM_LLS; i++) begin
      cand = rr_q + LL_W'(i);  // Wraps in LL_W bits
      if (!found && ll_v[cand]) begin
        found = 1'b1;
        win   = cand;
      end
    end
  end

  assign ll_pop    = issue_rdy & found;  // Held off while not ready
  assign ll_pop_ll = win;

  always_ff @(posedge prim_nonflr_clk or negedge prim_gated_rst_b) begin
    if (!prim_gated_rst_b) begin
      rr_q    <= '0;
      issue_v <= 1'b0;
    end else begin
      issue_v <= ll_pop;
      if (ll_pop) begin
        rr_q <= win + LL_W'(1);  // One past the winner
      end
    end
  end

  // Issue payload
  always_ff @(posedge prim_nonflr_clk) begin
    if (ll_pop) begin
      issue <= '{ll: win, ptr: ll_hptr[win]};
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/blk_pool_pkg.sv
rtl/blk_ll_mgr.sv
rtl/ll_issue_arb.sv
rtl/cpl_return_q.sv
rtl/blk_pool_top.sv
testbench/tb_blk_pool.sv

// ==== include/blk_pool_model.svh ====
// ------------------------------
// Block pool reference model
// FL, per-list and outstanding queues with round-robin prediction,
// advanced once per clock edge
// ------------------------------
`ifndef BLK_POOL_MODEL_SVH
`define BLK_POOL_MODEL_SVH

// Expects blk_pool_pkg imported in the enclosing module
logic [PTR_W-1:0] m_fl [$];            // Free list with the head first
logic [PTR_W-1:0] m_ll [NUM_LLS][$];   // Per-list queues
logic [PTR_W-1:0] m_out [$];           // Issued, not yet completed
logic [PTR_W-1:0] m_nxt [FL_DEPTH];    // Link store as the DUT holds it
logic [PTR_W-1:0] m_fl_h;
logic [PTR_W-1:0] m_fl_t;
logic [PTR_W-1:0] m_ll_h [NUM_LLS];    // Keep last value once drained
logic [PTR_W-1:0] m_ll_t [NUM_LLS];
logic [LL_W-1:0]  m_rr;
bit               m_exp_v;             // Issue expected after this edge
issue_t           m_exp;

function automatic void reset_queues();
  m_fl.delete();
  m_out.delete();
  for (int i = 0; i < FL_DEPTH; i++) begin
    m_fl.push_back(PTR_W'(i));
    m_nxt[i] = PTR_W'(i + 1);
  end
  for (int l = 0; l < NUM_LLS; l++) begin
    m_ll[l].delete();
    m_ll_h[l] = '0;
    m_ll_t[l] = '0;
  end
  m_fl_h  = '0;
  m_fl_t  = PTR_W'(FL_DEPTH - 1);
  m_rr    = '0;
  m_exp_v = 1'b0;
  m_exp   = '0;
endfunction

// One clock edge applied as list pop then alloc then FL push
function automatic void apply_edge(bit alloc_v, logic [LL_W-1:0] alloc_ll,
                                   bit issue_rdy, bit cpl_v);
  logic [LL_W-1:0]  win;
  logic [LL_W-1:0]  cand;
  logic [PTR_W-1:0] blk;
  logic [PTR_W-1:0] ret;
  bit               found;
  found   = 1'b0;
  win     = m_rr;
  for (int i = 0; i < NUM_LLS; i++) begin
    cand = m_rr + LL_W'(i);
    if (!found && (m_ll[cand].size() != 0)) begin
      found = 1'b1;
      win   = cand;
    end
  end
  m_exp_v = found && issue_rdy;
  if (m_exp_v) begin
    m_exp = '{ll: win, ptr: m_ll[win].pop_front()};
    m_out.push_back(m_exp.ptr);
    if (m_ll[win].size() != 0) begin
      m_ll_h[win] = m_ll[win][0];
    end
    m_rr = win + LL_W'(1);
  end
  if (alloc_v) begin
    blk = m_fl.pop_front();
    if (m_fl.size() != 0) begin
      m_fl_h = m_fl[0];
    end else begin
      m_fl_h = m_nxt[blk];  // Stale link once the FL runs dry
    end
    if (m_ll[alloc_ll].size() != 0) begin
      m_nxt[m_ll_t[alloc_ll]] = blk;
    end else begin
      m_ll_h[alloc_ll] = blk;
    end
    m_ll_t[alloc_ll] = blk;
    m_ll[alloc_ll].push_back(blk);
  end
  if (cpl_v) begin
    ret = m_out.pop_front();
    if (m_fl.size() == 0) begin
      m_fl_h = ret;          // Empty or emptied FL restarts here
    end else begin
      m_nxt[m_fl_t] = ret;
    end
    m_fl_t = ret;
    m_fl.push_back(ret);
  end
endfunction

function automatic fl_status_t expected_fl_stat(logic [PTR_W-1:0] lim);
  return '{full:   m_fl.size() == FL_DEPTH,
           aempty: m_fl.size() <= int'(lim),
           empty:  m_fl.size() == 0,
           cnt:    CNT_W'(m_fl.size()),
           hptr:   m_fl_h};
endfunction

function automatic logic [NUM_LLS-1:0] list_valid_bits();
  logic [NUM_LLS-1:0] v;
  for (int l = 0; l < NUM_LLS; l++) begin
    v[l] = (m_ll[l].size() != 0);
  end
  return v;
endfunction

function automatic ll_status_t list_read_word(logic [LL_W-1:0] l);
  return '{kind: 1'b1, v: m_ll[l].size() != 0, hptr: m_ll_h[l], tptr: m_ll_t[l]};
endfunction

function automatic ll_status_t block_read_word(logic [PTR_W-1:0] b);
  return '{kind: 1'b0, v: 1'b0, hptr: '0, tptr: m_nxt[b]};
endfunction

`endif

// ==== testbench/tb_blk_pool.sv ====
// ------------------------------
// Block pool testbench
// Random alloc, issue and completion traffic checked each cycle
// against the queue model, plus status reads
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_blk_pool;

  import blk_pool_pkg::*;

  `include "blk_pool_model.svh"

  // Run length ------------------------------
  localparam int CLK_NS        = 8;
  localparam int RST_CYC       = 16;
  localparam int T1_CYC        = 4;
  localparam int T2_CYC        = 16;    // Whole pool handed out
  localparam int T3_CYC        = 18;
  localparam int T4_CPL_CYC    = 18;
  localparam int T4_ALLOC_CYC  = 8;
  localparam int T5_CYC        = 2000;
  localparam int T6_ALLOC_CYC  = 6;
  localparam int T6_BLK_READS  = 6;
  localparam int T6_CYC        = T6_ALLOC_CYC + 3 * (NUM_LLS + T6_BLK_READS + 1);
  localparam int TOTAL_CYC     = RST_CYC + 1 + T1_CYC + T2_CYC + T3_CYC + T4_CPL_CYC
                                 + T4_ALLOC_CYC + T5_CYC + T6_CYC + 1;

  localparam fl_status_t RESET_FL = '{full: 1'b1, aempty: 1'b0, empty: 1'b0,
                                      cnt: CNT_W'(FL_DEPTH), hptr: '0};

  logic               prim_nonflr_clk = 1'b0;
  logic               prim_gated_rst_b;
  logic               alloc_v;
  logic [LL_W-1:0]    alloc_ll;
  logic               issue_rdy;
  logic               cpl_v;
  ll_ctl_t            cfg;
  fl_status_t         fl_stat;
  ll_status_t         ll_stat;
  logic [NUM_LLS-1:0] ll_v;
  logic               issue_v;
  issue_t             issue;

  ll_status_t         exp_stat;    // Expected status register
  ll_ctl_t            prev_ctl;    // cfg seen at the last edge
  logic [PTR_W-1:0]   edge_lim;    // aempty_lim at the last edge
  int                 err_cnt = 0;
  int                 test_err0 = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;

  always #(CLK_NS / 2) prim_nonflr_clk = ~prim_nonflr_clk;

  blk_pool_top DUT (
    .prim_nonflr_clk  (prim_nonflr_clk),
    .prim_gated_rst_b (prim_gated_rst_b),
    .alloc_v          (alloc_v),
    .alloc_ll         (alloc_ll),
    .issue_rdy        (issue_rdy),
    .cpl_v            (cpl_v),
    .cfg              (cfg),
    .fl_stat          (fl_stat),
    .ll_stat          (ll_stat),
    .ll_v             (ll_v),
    .issue_v          (issue_v),
    .issue            (issue)
  );

  // ------------------------------
  // Compare tasks

  task automatic fl_stat_cmp(input fl_status_t got, input fl_status_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error: fl_stat got 0x%03h expected 0x%03h at %0t", got, exp, $time);
    end
  endtask

  task automatic ll_stat_cmp(input ll_status_t got, input ll_status_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error: ll_stat got 0x%03h expected 0x%03h at %0t", got, exp, $time);
    end
  endtask

  task automatic issue_cmp(input logic got_v, input issue_t got,
                           input bit exp_v, input issue_t exp);
    if (got_v !== exp_v) begin
      err_cnt++;
      $display("Error: issue_v got 0x%0h expected 0x%0h at %0t", got_v, exp_v, $time);
    end else if (exp_v && (got !== exp)) begin
      err_cnt++;
      $display("Error: issue got 0x%02h expected 0x%02h at %0t", got, exp, $time);
    end
  endtask

  task automatic ll_v_cmp(input logic [NUM_LLS-1:0] got, input logic [NUM_LLS-1:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error: ll_v got 0x%01h expected 0x%01h at %0t", got, exp, $time);
    end
  endtask

  // ------------------------------
  // Cycle helpers

  function automatic void advance_model(input bit a_v, input logic [LL_W-1:0] a_ll,
                                        input bit rdy, input bit c_v, input ll_ctl_t ctl);
    // Read edges see the state before this clock edge
    if (ctl.rd_blk && !prev_ctl.rd_blk) begin
      exp_stat = block_read_word(ctl.ptr);
    end else if (ctl.rd_ll && !prev_ctl.rd_ll) begin
      exp_stat = list_read_word(ctl.ptr[LL_W-1:0]);
    end
    prev_ctl = ctl;
    edge_lim = ctl.aempty_lim;
    apply_edge(a_v, a_ll, rdy, c_v);
  endfunction

  task automatic compare_all();
    fl_stat_cmp(fl_stat, expected_fl_stat(edge_lim));
    ll_stat_cmp(ll_stat, exp_stat);
    ll_v_cmp(ll_v, list_valid_bits());
    issue_cmp(issue_v, issue, m_exp_v, m_exp);
  endtask

  // Starts and ends on a rising edge
  task automatic run_edge(input bit a_v, input logic [LL_W-1:0] a_ll,
                          input bit rdy, input bit c_v, input ll_ctl_t ctl);
    alloc_v   <= a_v;
    alloc_ll  <= a_ll;
    issue_rdy <= rdy;
    cpl_v     <= c_v;
    cfg       <= ctl;
    @(negedge prim_nonflr_clk);
    compare_all();             // Results of the previous edge
    @(posedge prim_nonflr_clk);
    advance_model(a_v, a_ll, rdy, c_v, ctl);
  endtask

  // Rising read then a held read on another index then release
  task automatic read_status(input bit rd_ll, input bit rd_blk, input logic [PTR_W-1:0] ptr);
    ll_ctl_t ctl;
    ctl        = '0;
    ctl.rd_ll  = rd_ll;
    ctl.rd_blk = rd_blk;
    ctl.ptr    = ptr;
    run_edge(1'b0, '0, 1'b0, 1'b0, ctl);
    ctl.ptr    = ptr + PTR_W'(5);  // Must not reload
    run_edge(1'b0, '0, 1'b0, 1'b0, ctl);
    run_edge(1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic report_test(input string name);
    int n;
    n = err_cnt - test_err0;
    tests_run++;
    if (n != 0) begin
      tests_failed++;
    end
    $display("Test %-14s %s, %0d errors", name, (n == 0) ? "ok" : "mismatch", n);
    test_err0 = err_cnt;
  endtask

  // ------------------------------
  // Watchdog over the whole run plus 20 %

  initial begin
    #(TOTAL_CYC * 12 / 10 * CLK_NS);
    $display("Error: run did not finish within %0d cycles", TOTAL_CYC * 12 / 10);
    $display("*** FAILED ***");
    $finish;
  end

  // ------------------------------
  // Test sequence

  initial begin
    ll_ctl_t ctl;
    bit      a;
    bit      c;
    bit      rdy;
    void'($urandom(32'hc741_7f61));
    prim_gated_rst_b = 1'b0;
    alloc_v          = 1'b0;
    alloc_ll         = '0;
    issue_rdy        = 1'b0;
    cpl_v            = 1'b0;
    cfg              = '0;
    prev_ctl         = '0;
    exp_stat         = '0;
    edge_lim         = '0;
    reset_queues();
    repeat (RST_CYC) @(posedge prim_nonflr_clk);
    prim_gated_rst_b <= 1'b1;

    // Reset values with issue held off
    @(negedge prim_nonflr_clk);
    fl_stat_cmp(fl_stat, RESET_FL);
    ll_v_cmp(ll_v, '0);
    @(posedge prim_nonflr_clk);
    advance_model(1'b0, '0, 1'b0, 1'b0, '0);
    repeat (T1_CYC) run_edge(1'b0, '0, 1'b0, 1'b0, '0);
    report_test("after reset");

    // Drain the FL into the lists with issue held off
    ctl            = '0;
    ctl.aempty_lim = PTR_W'(5);
    for (int i = 0; i < T2_CYC; i++) begin
      run_edge(1'b1, (i < NUM_LLS) ? LL_W'(i) : LL_W'($urandom), 1'b0, 1'b0, ctl);
    end
    report_test("allocation");

    // Round-robin issue of every block
    repeat (T3_CYC) run_edge(1'b0, '0, 1'b1, 1'b0, ctl);
    report_test("issue order");

    // Return all blocks and then reuse them
    repeat (T4_CPL_CYC) run_edge(1'b0, '0, 1'b0, m_out.size() != 0, ctl);
    repeat (T4_ALLOC_CYC) run_edge(m_fl.size() != 0, LL_W'($urandom), 1'b0, 1'b0, ctl);
    report_test("completion");

    // Mixed traffic with legal strobes only
    for (int i = 0; i < T5_CYC; i++) begin
      ctl            = '0;
      ctl.aempty_lim = PTR_W'($urandom);
      a              = (m_fl.size() != 0) && (($urandom % 4) != 0);
      rdy            = ($urandom % 3) != 0;
      // A block issued on this edge may complete on it too
      c              = ((m_out.size() != 0) || (rdy && (list_valid_bits() != '0)))
                       && (($urandom % 2) == 0);
      run_edge(a, LL_W'($urandom), rdy, c, ctl);
    end
    report_test("mixed traffic");

    // Status reads over a few filled lists
    for (int i = 0; i < T6_ALLOC_CYC; i++) begin
      run_edge(m_fl.size() != 0, LL_W'($urandom), 1'b0, m_out.size() != 0, '0);
    end
    for (int l = 0; l < NUM_LLS; l++) begin
      read_status(1'b1, 1'b0, PTR_W'(l));
    end
    for (int i = 0; i < T6_BLK_READS; i++) begin
      read_status(1'b0, 1'b1, PTR_W'($urandom));
    end
    read_status(1'b1, 1'b1, PTR_W'(2));  // Block read wins
    @(negedge prim_nonflr_clk);
    compare_all();
    report_test("status reads");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
